// File: hw/ppu_pkg.sv
package ppu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Scan timing
    //////////////////////////////////////////////////////////////////////
    localparam logic [8:0] H_TOTAL      = 9'd456;   // Cycles per line
    localparam logic [8:0] H_OAM_END    = 9'd80;    // OAM search length
    localparam logic [8:0] H_PIX_LEN    = 9'd168;   // Scan positions per line
    localparam logic [8:0] H_SYNC_START = 9'd76;
    localparam logic [8:0] H_SYNC_LEN   = 9'd4;
    localparam logic [7:0] V_ACTIVE     = 8'd144;   // Visible lines
    localparam logic [7:0] V_SYNC_LINE  = 8'd153;
    localparam logic [7:0] V_TOTAL      = 8'd154;

    // Objects
    localparam int         OAM_ENTRIES  = 40;       // 4 bytes each
    localparam logic [7:0] OBJ_Y_OFFSET = 8'd16;
    localparam int         NUM_SLOTS    = 10;       // Object limit per line

    //////////////////////////////////////////////////////////////////////
    // CPU bus map
    //////////////////////////////////////////////////////////////////////
    localparam logic [15:0] ADDR_LCDC = 16'hFF40;
    localparam logic [15:0] ADDR_STAT = 16'hFF41;
    localparam logic [15:0] ADDR_LY   = 16'hFF44;
    localparam logic [15:0] ADDR_LYC  = 16'hFF45;
    localparam logic [15:0] OAM_BASE  = 16'hFE00;
    localparam logic [15:0] OAM_LAST  = 16'hFE9F;

    // Register fields
    localparam int LCDC_EN_BIT       = 7;
    localparam int LCDC_OBJ_SIZE_BIT = 2;   // 1 selects 8x16 objects
    localparam int LCDC_OBJ_EN_BIT   = 1;
    localparam int STAT_LYC_INT_BIT  = 6;
    localparam int STAT_OAM_INT_BIT  = 5;
    localparam int STAT_VBL_INT_BIT  = 4;
    localparam int STAT_HBL_INT_BIT  = 3;
    localparam int STAT_COIN_BIT     = 2;

    typedef enum logic [1:0] {
        MODE_HBLANK = 2'd0,
        MODE_VBLANK = 2'd1,
        MODE_OAM    = 2'd2,
        MODE_PIX    = 2'd3
    } ppu_mode_t;

    typedef logic [3:0] slot_idx_t;
    typedef logic [5:0] oam_idx_t;

endpackage

// File: hw/ppu_if.sv
`timescale 1ns/1ns

// Scan position and mode, shared by every block that follows the beam
interface line_timing_if;
    logic [8:0]         h_count;
    logic [7:0]         v_count;
    ppu_pkg::ppu_mode_t mode;
    logic [7:0]         h_pix;       // Valid in MODE_PIX only
    logic               line_start;

    modport source (output h_count, v_count, mode, h_pix, line_start);
    modport sink   (input  h_count, v_count, mode, h_pix, line_start);
endinterface

// Slot fill from the OAM search
interface oam_load_if;
    logic                clear;
    logic                load;
    ppu_pkg::slot_idx_t  slot;
    ppu_pkg::oam_idx_t   index;
    logic [7:0]          x;

    modport source (output clear, load, slot, index, x);
    modport sink   (input  clear, load, slot, index, x);
endinterface

// File: hw/lcd_timing.sv
`timescale 1ns/1ns

module lcd_timing (
    input  logic               clk,
    input  logic               rst,
    input  logic               lcd_en,
    line_timing_if.source      tim,
    output logic               hs,
    output logic               vs
);

    logic [8:0] h_cnt;
    logic [7:0] v_cnt;
    logic [8:0] h_rel;
    logic       h_wrap;

    assign h_wrap = (h_cnt == ppu_pkg::H_TOTAL - 9'd1);

    // Counters and sync, all held at zero while the LCD is off
    always_ff @(posedge clk) begin
        if (rst || !lcd_en) begin
            h_cnt <= '0;
            v_cnt <= '0;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end else begin
            h_cnt <= h_wrap ? 9'd0 : h_cnt + 9'd1;
            if (h_wrap) begin
                v_cnt <= (v_cnt == ppu_pkg::V_TOTAL - 8'd1) ? 8'd0 : v_cnt + 8'd1;
                if (v_cnt == ppu_pkg::V_SYNC_LINE - 8'd1)
                    vs <= 1'b1;                 // Whole of the last line
                else if (v_cnt == ppu_pkg::V_SYNC_LINE)
                    vs <= 1'b0;
            end
            if (h_cnt == ppu_pkg::H_SYNC_START - 9'd1)
                hs <= 1'b1;
            else if (h_cnt == ppu_pkg::H_SYNC_START + ppu_pkg::H_SYNC_LEN - 9'd1)
                hs <= 1'b0;
        end
    end

    // Mode from the counters
    always_comb begin
        if (!lcd_en || v_cnt >= ppu_pkg::V_ACTIVE)
            tim.mode = ppu_pkg::MODE_VBLANK;
        else if (h_cnt < ppu_pkg::H_OAM_END)
            tim.mode = ppu_pkg::MODE_OAM;
        else if (h_cnt < ppu_pkg::H_OAM_END + ppu_pkg::H_PIX_LEN)
            tim.mode = ppu_pkg::MODE_PIX;
        else
            tim.mode = ppu_pkg::MODE_HBLANK;
    end

    assign h_rel          = h_cnt - ppu_pkg::H_OAM_END;
    assign tim.h_pix      = h_rel[7:0];    // Scan position in pixel transfer
    assign tim.h_count    = h_cnt;
    assign tim.v_count    = v_cnt;
    assign tim.line_start = lcd_en && (h_cnt == 9'd0) && (v_cnt < ppu_pkg::V_ACTIVE);

endmodule

// File: hw/ppu_regs.sv
`timescale 1ns/1ns

module ppu_regs (
    input  logic          clk,
    input  logic          rst,
    input  logic [15:0]   a,
    input  logic [7:0]    d_wr,
    input  logic          wr,
    input  logic [7:0]    oam_rd_data,
    line_timing_if.sink   tim,
    output logic [7:0]    d_rd,
    output logic          lcd_en,
    output logic          obj_size,
    output logic          obj_en,
    input  logic          int_vblank_ack,
    input  logic          int_lcdc_ack,
    output logic          int_vblank_req,
    output logic          int_lcdc_req
);

    logic [7:0]         lcdc;
    logic [7:3]         stat_en;       // Interrupt source enables
    logic [7:0]         lyc;
    logic [7:0]         stat_rd;
    logic               coin;
    logic               coin_q;
    ppu_pkg::ppu_mode_t mode_q;
    logic               in_oam;
    logic               vbl_entry;
    logic               lcdc_set;

    assign lcd_en   = lcdc[ppu_pkg::LCDC_EN_BIT];
    assign obj_size = lcdc[ppu_pkg::LCDC_OBJ_SIZE_BIT];
    assign obj_en   = lcdc[ppu_pkg::LCDC_OBJ_EN_BIT];

    assign coin   = (tim.v_count == lyc);  // LY is the line counter itself
    assign in_oam = (a >= ppu_pkg::OAM_BASE) && (a <= ppu_pkg::OAM_LAST);

    //////////////////////////////////////////////////////////////////////
    // Interrupt edges against the previous cycle
    //////////////////////////////////////////////////////////////////////
    assign vbl_entry = (tim.mode == ppu_pkg::MODE_VBLANK) && (mode_q != ppu_pkg::MODE_VBLANK)
                       && (tim.v_count == ppu_pkg::V_ACTIVE);

    assign lcdc_set =
        (stat_en[ppu_pkg::STAT_LYC_INT_BIT] && coin && !coin_q) ||
        (stat_en[ppu_pkg::STAT_OAM_INT_BIT] && (tim.mode == ppu_pkg::MODE_OAM)
            && (mode_q != ppu_pkg::MODE_OAM)) ||
        (stat_en[ppu_pkg::STAT_VBL_INT_BIT] && vbl_entry) ||
        (stat_en[ppu_pkg::STAT_HBL_INT_BIT] && (tim.mode == ppu_pkg::MODE_HBLANK)
            && (mode_q != ppu_pkg::MODE_HBLANK));

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc           <= '0;
            stat_en        <= '0;
            lyc            <= '0;
            mode_q         <= ppu_pkg::MODE_VBLANK;
            coin_q         <= 1'b0;
            int_vblank_req <= 1'b0;
            int_lcdc_req   <= 1'b0;
        end else begin
            mode_q <= tim.mode;
            coin_q <= coin;
            if (int_vblank_ack)            // Ack beats a new request
                int_vblank_req <= 1'b0;
            else if (vbl_entry)
                int_vblank_req <= 1'b1;
            if (int_lcdc_ack)
                int_lcdc_req <= 1'b0;
            else if (lcdc_set)
                int_lcdc_req <= 1'b1;
            if (wr) begin
                case (a)
                    ppu_pkg::ADDR_LCDC: lcdc    <= d_wr;
                    ppu_pkg::ADDR_STAT: stat_en <= d_wr[7:3];
                    ppu_pkg::ADDR_LYC:  lyc     <= d_wr;
                    default: ;         // LY is read only
                endcase
            end
        end
    end

    // Combinational read data
    always_comb begin
        stat_rd                         = '0;
        stat_rd[7:3]                    = stat_en;
        stat_rd[ppu_pkg::STAT_COIN_BIT] = coin;
        stat_rd[1:0]                    = tim.mode;
        case (a)
            ppu_pkg::ADDR_LCDC: d_rd = lcdc;
            ppu_pkg::ADDR_STAT: d_rd = stat_rd;
            ppu_pkg::ADDR_LY:   d_rd = tim.v_count;
            ppu_pkg::ADDR_LYC:  d_rd = lyc;
            default:            d_rd = in_oam ? oam_rd_data : 8'hFF;
        endcase
    end

endmodule

// File: hw/oam_scanner.sv
`timescale 1ns/1ns

module oam_scanner (
    input  logic          clk,
    input  logic          rst,
    input  logic [15:0]   a,
    input  logic [7:0]    d_wr,
    input  logic          wr,
    input  logic          obj_size,
    line_timing_if.sink   tim,
    output logic [7:0]    oam_rd_data,
    oam_load_if.source    load
);

    logic [7:0] oam_mem [0:4*ppu_pkg::OAM_ENTRIES-1];

    logic               in_oam;
    logic               bus_ok;        // CPU owns OAM in the blank modes
    ppu_pkg::oam_idx_t  search_idx;
    logic [7:0]         obj_y;
    logic [8:0]         y_top;         // LY + 16
    logic [8:0]         y_height;
    logic               y_ok;
    ppu_pkg::slot_idx_t vis_count;
    logic               searching;

    assign in_oam = (a >= ppu_pkg::OAM_BASE) && (a <= ppu_pkg::OAM_LAST);
    assign bus_ok = (tim.mode == ppu_pkg::MODE_HBLANK) || (tim.mode == ppu_pkg::MODE_VBLANK);

    always_ff @(posedge clk) begin
        if (wr && in_oam && bus_ok)
            oam_mem[a[7:0]] <= d_wr;
    end

    assign oam_rd_data = bus_ok ? oam_mem[a[7:0]] : 8'hFF;

    //////////////////////////////////////////////////////////////////////
    // Y search, one entry per cycle pair
    //////////////////////////////////////////////////////////////////////
    assign search_idx = tim.h_count[6:1];
    assign searching  = (tim.mode == ppu_pkg::MODE_OAM);   // 80 cycles cover all 40 entries
    assign obj_y      = oam_mem[{search_idx, 2'b00}];
    assign y_top      = {1'b0, tim.v_count} + {1'b0, ppu_pkg::OBJ_Y_OFFSET};
    assign y_height   = obj_size ? 9'd16 : 9'd8;

    always_ff @(posedge clk) begin
        if (rst) begin
            y_ok      <= 1'b0;
            vis_count <= '0;
        end else begin
            if (tim.line_start)
                vis_count <= '0;
            else if (load.load)
                vis_count <= vis_count + 4'd1;
            // Compare in the even cycle and load in the odd one
            if (searching && !tim.h_count[0])
                y_ok <= (obj_y != 8'd0) && ({1'b0, obj_y} <= y_top)
                        && ({1'b0, obj_y} > y_top - y_height);
            else
                y_ok <= 1'b0;
        end
    end

    assign load.clear = tim.line_start;
    assign load.load  = y_ok && searching && tim.h_count[0]
                        && (vis_count < ppu_pkg::slot_idx_t'(ppu_pkg::NUM_SLOTS));
    assign load.slot  = vis_count;
    assign load.index = search_idx;
    assign load.x     = oam_mem[{search_idx, 2'b01}];  // X byte of the same entry

endmodule

// File: hw/sprite_slot.sv
`timescale 1ns/1ns

module sprite_slot #(
    parameter int SLOT_ID = 0
) (
    input  logic              clk,
    input  logic              rst,
    oam_load_if.sink          load,
    line_timing_if.sink       tim,
    output logic              match,
    output ppu_pkg::oam_idx_t index
);

    logic       valid;
    logic [7:0] obj_x;

    always_ff @(posedge clk) begin
        if (rst || load.clear)
            valid <= 1'b0;                 // Empty at the start of each line
        else if (load.load && load.slot == ppu_pkg::slot_idx_t'(SLOT_ID))
            valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (load.load && load.slot == ppu_pkg::slot_idx_t'(SLOT_ID)) begin
            index <= load.index;
            obj_x <= load.x;
        end
    end

    assign match = valid && (obj_x == tim.h_pix);   // Object starts here

endmodule

// File: hw/sprite_select.sv
`timescale 1ns/1ns

module sprite_select (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           obj_en,
    line_timing_if.sink                    tim,
    input  logic [ppu_pkg::NUM_SLOTS-1:0]  match,
    input  ppu_pkg::oam_idx_t              index [ppu_pkg::NUM_SLOTS],
    output logic                           obj_hit,
    output ppu_pkg::oam_idx_t              obj_index
);

    logic              pick_hit;
    ppu_pkg::oam_idx_t pick_idx;

    // Lowest matching slot wins, the rest at this position are dropped
    always_comb begin
        pick_hit = 1'b0;
        pick_idx = index[0];
        for (int i = ppu_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
            if (match[i]) begin
                pick_hit = 1'b1;
                pick_idx = index[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            obj_hit <= 1'b0;
        else
            obj_hit <= pick_hit && obj_en && (tim.mode == ppu_pkg::MODE_PIX);
    end

    always_ff @(posedge clk) begin
        obj_index <= pick_idx;
    end

endmodule

// File: hw/ppu_top.sv
`timescale 1ns/1ns

module ppu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic [15:0]       a,
    input  logic [7:0]        d_wr,
    input  logic              wr,
    output logic [7:0]        d_rd,
    output logic              int_vblank_req,
    output logic              int_lcdc_req,
    input  logic              int_vblank_ack,
    input  logic              int_lcdc_ack,
    output logic              hs,
    output logic              vs,
    output logic              obj_hit,
    output ppu_pkg::oam_idx_t obj_index
);

    line_timing_if tim_if ();
    oam_load_if    load_if ();

    logic                          lcd_en;
    logic                          obj_size;
    logic                          obj_en;
    logic [7:0]                    oam_rd_data;
    logic [ppu_pkg::NUM_SLOTS-1:0] slot_match;
    ppu_pkg::oam_idx_t             slot_index [ppu_pkg::NUM_SLOTS];

    lcd_timing u_timing (
        .clk(clk), .rst(rst), .lcd_en(lcd_en), .tim(tim_if.source), .hs(hs), .vs(vs)
    );

    ppu_regs u_regs (
        .clk(clk), .rst(rst), .a(a), .d_wr(d_wr), .wr(wr), .oam_rd_data(oam_rd_data),
        .tim(tim_if.sink), .d_rd(d_rd), .lcd_en(lcd_en), .obj_size(obj_size),
        .obj_en(obj_en), .int_vblank_ack(int_vblank_ack), .int_lcdc_ack(int_lcdc_ack),
        .int_vblank_req(int_vblank_req), .int_lcdc_req(int_lcdc_req)
    );

    oam_scanner u_scan (
        .clk(clk), .rst(rst), .a(a), .d_wr(d_wr), .wr(wr), .obj_size(obj_size),
        .tim(tim_if.sink), .oam_rd_data(oam_rd_data), .load(load_if.source)
    );

    // One slot per visible object
    for (genvar i = 0; i < ppu_pkg::NUM_SLOTS; i++) begin : g_slot
        sprite_slot #(.SLOT_ID(i)) u_slot (
            .clk(clk), .rst(rst), .load(load_if.sink), .tim(tim_if.sink),
            .match(slot_match[i]), .index(slot_index[i])
        );
    end

    sprite_select u_select (
        .clk(clk), .rst(rst), .obj_en(obj_en), .tim(tim_if.sink), .match(slot_match),
        .index(slot_index), .obj_hit(obj_hit), .obj_index(obj_index)
    );

endmodule

// File: verification/ppu_asserts.sv
`timescale 1ns/1ns

module ppu_asserts (
    input logic               clk,
    input logic               rst,
    input logic               hs,
    input logic               vs,
    input logic               lcd_en,
    input logic [8:0]         h_count,
    input logic [7:0]         v_count,
    input ppu_pkg::ppu_mode_t mode,
    input logic               int_vblank_req,
    input logic               int_vblank_ack,
    input logic               int_lcdc_req,
    input logic               int_lcdc_ack,
    input logic               obj_hit
);

    int fail_count = 0;   // Watched by the testbench

    ////////////////////////////////////////////////////////////////////
    // Scan timing and sync
    ////////////////////////////////////////////////////////////////////
    hs_window: assert property (@(posedge clk) disable iff (rst)
        hs |-> (h_count >= 9'd76 && h_count <= 9'd79))
        else begin
            $error("hs high outside h_count 76 to 79");
            fail_count++;
        end

    vs_line: assert property (@(posedge clk) disable iff (rst)
        vs |-> (v_count == 8'd153))
        else begin
            $error("vs high outside line 153");
            fail_count++;
        end

    lcd_off_hold: assert property (@(posedge clk) disable iff (rst)
        (!lcd_en && !$past(lcd_en)) |-> (h_count == 9'd0 && v_count == 8'd0 && !hs && !vs
            && mode == ppu_pkg::MODE_VBLANK))
        else begin
            $error("Timing not held while the LCD is off");
            fail_count++;
        end

    // Request and acknowledge rules
    vbl_ack_wins: assert property (@(posedge clk) disable iff (rst)
        int_vblank_ack |=> !int_vblank_req)
        else begin
            $error("V-blank request survived its acknowledge");
            fail_count++;
        end

    vbl_hold: assert property (@(posedge clk) disable iff (rst)
        (int_vblank_req && !int_vblank_ack) |=> int_vblank_req)
        else begin
            $error("V-blank request dropped without acknowledge");
            fail_count++;
        end

    lcdc_ack_wins: assert property (@(posedge clk) disable iff (rst)
        int_lcdc_ack |=> !int_lcdc_req)
        else begin
            $error("LCDC request survived its acknowledge");
            fail_count++;
        end

    lcdc_hold: assert property (@(posedge clk) disable iff (rst)
        (int_lcdc_req && !int_lcdc_ack) |=> int_lcdc_req)
        else begin
            $error("LCDC request dropped without acknowledge");
            fail_count++;
        end

    hit_in_pix: assert property (@(posedge clk) disable iff (rst)
        obj_hit |-> ($past(mode) == ppu_pkg::MODE_PIX))
        else begin
            $error("Object hit outside pixel transfer");
            fail_count++;
        end

endmodule

bind ppu_top ppu_asserts asserts_i (
    .clk(clk), .rst(rst), .hs(hs), .vs(vs), .lcd_en(lcd_en),
    .h_count(tim_if.h_count), .v_count(tim_if.v_count), .mode(tim_if.mode),
    .int_vblank_req(int_vblank_req), .int_vblank_ack(int_vblank_ack),
    .int_lcdc_req(int_lcdc_req), .int_lcdc_ack(int_lcdc_ack), .obj_hit(obj_hit)
);

// File: verification/tb_ppu.sv
`timescale 1ns/1ns

module tb_ppu;

    localparam int PERIOD_NS    = 20;
    localparam int FRAME_CYCLES = 456 * 154;
    localparam int WATCHDOG_NS  = 4 * FRAME_CYCLES * PERIOD_NS;  // Enable plus 3 frames
    localparam int TEST_LINE    = 20;

    logic clk = 1'b0;
    logic rst, wr, int_vblank_ack, int_lcdc_ack;
    logic [15:0] a;
    logic [7:0]  d_wr, d_rd;
    logic int_vblank_req, int_lcdc_req, hs, vs, obj_hit;
    ppu_pkg::oam_idx_t obj_index;

    logic [15:0] lfsr_state = 16'd3966;
    logic [7:0]  oam_img [0:159];
    int m_h, m_v, hs_cnt, vs_cnt;
    bit m_en, obj_size_m, obj_en_m, line_armed, frame_armed;
    logic [7:0] rd;
    int mode_pos [8] = '{0, 40, 79, 80, 200, 247, 248, 455};   // Around the mode edges

    ppu_top dut_i (
        .clk(clk), .rst(rst), .a(a), .d_wr(d_wr), .wr(wr), .d_rd(d_rd),
        .int_vblank_req(int_vblank_req), .int_lcdc_req(int_lcdc_req),
        .int_vblank_ack(int_vblank_ack), .int_lcdc_ack(int_lcdc_ack),
        .hs(hs), .vs(vs), .obj_hit(obj_hit), .obj_index(obj_index)
    );

    always #(PERIOD_NS / 2) clk = ~clk;

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        logic b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];                          // Galois step, taps 16,14,13,11
            lfsr_state = lfsr_state >> 1;
            if (b)
                lfsr_state = lfsr_state ^ 16'hB400;
            v = {v[6:0], b};
        end
        return v;
    endfunction

    function automatic int exp_mode(input int h, input int v);
        if (v >= 144) return 1;
        if (h < 80)   return 2;
        if (h < 248)  return 3;
        return 0;
    endfunction

    task automatic expect_true(input bit ok, input string msg);
        assert (ok) else begin
            $display("Mismatch at %0t ns: %s", $time, msg);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // Scan counter model that follows the LCDC enable bit
    always @(posedge clk) begin
        if (rst) begin
            m_h  <= 0;
            m_v  <= 0;
            m_en <= 1'b0;
        end else begin
            if (!m_en) begin
                m_h <= 0;
                m_v <= 0;
            end else if (m_h == 455) begin
                m_h <= 0;
                m_v <= (m_v == 153) ? 0 : m_v + 1;
            end else
                m_h <= m_h + 1;
            if (wr && a == 16'hFF40)
                m_en <= d_wr[7];
        end
    end

    // Sync widths per line and per frame
    always @(negedge clk) begin
        if (!m_en || rst) begin
            line_armed  = 0;
            frame_armed = 0;
        end else begin
            if (m_h == 0) begin
                if (line_armed)
                    expect_true(hs_cnt == 4, "hs not 4 cycles in a line");
                hs_cnt     = hs;
                line_armed = 1;
            end else
                hs_cnt += hs;
            if (m_h == 0 && m_v == 0) begin
                if (frame_armed)
                    expect_true(vs_cnt == 456, "vs not 456 cycles in a frame");
                vs_cnt      = vs;
                frame_armed = 1;
            end else
                vs_cnt += vs;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $fatal(1);
    end

    // Concurrent assertion failures end the run at once
    always @(dut_i.asserts_i.fail_count) begin
        if (dut_i.asserts_i.fail_count != 0) begin
            $display("A bound assertion failed at %0t ns", $time);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        a    = addr;
        d_wr = data;
        wr   = 1'b1;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        a  = addr;
        wr = 1'b0;
        #(PERIOD_NS / 4);
        data = d_rd;                 // Mid low phase, clear of both edges
        @(negedge clk);
    endtask

    task automatic wait_pos(input int h, input int v);
        while (!(m_h == h && m_v == v)) @(negedge clk);
    endtask

    // OAM search model for one line and the trigger check over the transfer
    task automatic check_line(input int line);
        int sel_idx [10];
        int sel_x [10];
        int n, y, hgt, k;
        bit hit;
        n = 0;
        hgt = obj_size_m ? 16 : 8;
        for (int e = 0; e < 40; e++) begin
            y = oam_img[4*e];
            if (y != 0 && y <= line + 16 && y > line + 16 - hgt && n < 10) begin
                sel_idx[n] = e;
                sel_x[n]   = oam_img[4*e+1];
                n++;
            end
        end
        wait_pos(81, line);
        for (int h = 81; h <= 249; h++) begin
            hit = 0;
            k   = 0;
            for (int s = n - 1; s >= 0; s--) begin
                if (sel_x[s] == h - 81 && h - 81 < 168) begin
                    hit = 1;
                    k   = s;
                end
            end
            hit = hit && obj_en_m;
            expect_true(obj_hit == hit, $sformatf("obj_hit at h_count %0d", h));
            if (hit)
                expect_true(obj_index == sel_idx[k], $sformatf("obj_index at h_count %0d", h));
            @(negedge clk);
        end
    endtask

    initial begin
        rst            = 1'b1;
        wr             = 1'b0;
        a              = '0;
        d_wr           = '0;
        int_vblank_ack = 1'b0;
        int_lcdc_ack   = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        expect_true(!hs && !vs && !obj_hit && !int_vblank_req && !int_lcdc_req,
                    "outputs active after reset");
        bus_read(16'hFF44, rd);
        expect_true(rd == 8'd0, "LY not 0 with LCD off");
        bus_read(16'hFF41, rd);
        expect_true(rd[1:0] == 2'd1, "STAT mode not 1 with LCD off");
        repeat (5) @(negedge clk);
        expect_true(!hs, "hs high with LCD off");

        ////////////////////////////////////////////////////////////////////
        // Random OAM contents with a crowd of objects on the test line
        ////////////////////////////////////////////////////////////////////
        for (int i = 0; i < 160; i++) oam_img[i] = rand_bits(8);
        for (int e = 0; e < 14; e++) begin
            oam_img[4*e]   = 8'(TEST_LINE + 16) - rand_bits(3);
            oam_img[4*e+1] = rand_bits(7);
        end
        oam_img[13] = oam_img[5];              // Two objects start together
        for (int i = 0; i < 160; i++) bus_write(16'hFE00 + 16'(i), oam_img[i]);
        for (int i = 0; i < 160; i++) begin
            bus_read(16'hFE00 + 16'(i), rd);
            expect_true(rd == oam_img[i], $sformatf("OAM readback at byte %0d", i));
        end

        bus_write(16'hFF40, 8'h82);
        obj_size_m = 0;
        obj_en_m   = 1;
        wait_pos(10, 1);
        bus_read(16'hFE04, rd);
        expect_true(rd == 8'hFF, "OAM read in OAM mode");
        wait_pos(100, 1);
        bus_read(16'hFE04, rd);
        expect_true(rd == 8'hFF, "OAM read in PIX mode");
        bus_write(16'hFE05, ~oam_img[5]);
        wait_pos(300, 1);
        bus_read(16'hFE05, rd);
        expect_true(rd == oam_img[5], "blocked OAM write changed the byte");

        foreach (mode_pos[i]) begin
            wait_pos(mode_pos[i], 2);
            bus_read(16'hFF41, rd);
            expect_true(rd[1:0] == 2'(exp_mode(mode_pos[i], 2)),
                        $sformatf("STAT mode at h %0d", mode_pos[i]));
        end
        for (int v = 3; v < 6; v++) begin
            wait_pos(300, v);
            bus_read(16'hFF44, rd);
            expect_true(rd == 8'(v), $sformatf("LY on line %0d", v));
        end
        check_line(TEST_LINE);

        wait_pos(0, 144);
        expect_true(!int_vblank_req, "V-blank request early");
        wait_pos(1, 144);
        expect_true(int_vblank_req, "V-blank request missing");
        int_vblank_ack = 1'b1;
        @(negedge clk);
        int_vblank_ack = 1'b0;
        expect_true(!int_vblank_req, "V-blank request not cleared by acknowledge");
        wait_pos(100, 150);
        bus_read(16'hFF41, rd);
        expect_true(rd[1:0] == 2'd1, "STAT mode in V-blank");
        bus_read(16'hFF44, rd);
        expect_true(rd == 8'd150, "LY on line 150");
        bus_write(16'hFF40, 8'h86);
        obj_size_m = 1;

        check_line(TEST_LINE);                 // 8x16 objects
        wait_pos(300, 30);
        bus_write(16'hFF45, 8'd50);
        bus_write(16'hFF41, 8'h40);
        wait_pos(0, 50);
        expect_true(!int_lcdc_req, "LYC request early");
        bus_read(16'hFF41, rd);
        expect_true(rd[2], "STAT coincidence flag on line 50");
        wait_pos(1, 50);
        expect_true(int_lcdc_req, "LYC request missing");
        int_lcdc_ack = 1'b1;
        @(negedge clk);
        int_lcdc_ack = 1'b0;
        expect_true(!int_lcdc_req, "LCDC request not cleared by acknowledge");
        wait_pos(100, 60);                     // H-blank source armed just before its edge
        bus_write(16'hFF41, 8'h08);
        wait_pos(248, 60);
        expect_true(!int_lcdc_req, "H-blank request early");
        wait_pos(249, 60);
        expect_true(int_lcdc_req, "H-blank request missing");
        int_lcdc_ack = 1'b1;
        @(negedge clk);
        int_lcdc_ack = 1'b0;
        bus_write(16'hFF41, 8'h00);
        wait_pos(100, 150);
        bus_write(16'hFF40, 8'h84);
        obj_en_m = 0;
        check_line(TEST_LINE);                 // Objects disabled so no hits

        if (dut_i.asserts_i.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
hw/ppu_pkg.sv
hw/ppu_if.sv
hw/lcd_timing.sv
hw/ppu_regs.sv
hw/oam_scanner.sv
hw/sprite_slot.sv
hw/sprite_select.sv
hw/ppu_top.sv
verification/ppu_asserts.sv
verification/tb_ppu.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ppu -f files.f -o sim_ppu

./obj_dir/sim_ppu > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASS" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
